//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuTb
FILELIST  = cpu.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- cpu.f
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/executeUnit.sv
verilog/writeBack.sv
verilog/pcUnit.sv
verilog/controlFsm.sv
verilog/cpu.sv
verif/cpuTb.sv

//--- verif/cpuGolden.hex
// Words 0-3: program length, data length, store count, loop factor
// Then program words, initial data words, and store pairs (address, data)
00000024 00000002 0000000E 00000002
// Arithmetic, logic and shifts on 0x123 and -16
20100123 20203FF0 04304200 10404200 08504200 0C604200
20800024 14704800 18908800
// Stores of the results
44300030 44400031 44500032 44600033 44700034 44900035
// Multiply with large operands
20A03FFD 1CB28200 1CC1C900 44B00036 44C00037
// Load, add, store at r14 + 0x10
40D00000 40E00001 00F34E00 44F38010
// Counted loop, then branches taken and not taken
21000003 21043FFF 45000040 8C043FFE 88040002 4410007F 88004005 8C000004
// Link and return through r17
81100002 45100051 45100050 84044000
// Initial data memory
DEADBEEF 00000011
// Expected stores
00000030 00000133 00000031 FFFFFED3 00000032 00000120 00000033 FFFFFFF3
00000034 00001230 00000035 0FFFFFFF 00000036 00000030 00000037 FFFFEDD0
00000021 DEADBF00 00000040 00000002 00000040 00000001 00000040 00000000
00000050 00000021 00000051 00000021

//--- verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

    localparam int DataWidth   = 32;
    localparam int MemWords    = 256;
    localparam int GoldenWords = 128;

    logic                 clock       = 1'b0;
    logic                 rstN        = 1'b0;
    logic [DataWidth-1:0] instr       = '0;
    logic                 instrLoaded = 1'b0;
    logic [DataWidth-1:0] dataIn      = '0;
    logic                 dataLoaded  = 1'b0;
    logic                 dataStored  = 1'b0;
    logic [DataWidth-1:0] instrAddr;
    logic [DataWidth-1:0] dataAddr;
    logic [DataWidth-1:0] dataOut;
    logic                 readInstr;
    logic                 readData;
    logic                 writeData;

    logic [31:0] golden [GoldenWords];
    logic [31:0] imem [MemWords];
    logic [31:0] dmem [MemWords];

    int     progLen;
    int     dataLen;
    int     storeCount;
    int     loopFactor;
    int     storeBase;
    int     storeIdx = 0;
    int     storesInProgram = 0;
    int     cycleCount = 0;
    int     cycleLimit;
    int     mismatchCount = 0;
    int     otherCount = 0;
    int     instrDelay = 0;
    int     dataDelay = 0;
    logic   instrWaiting = 1'b0;
    logic   dataWaiting = 1'b0;
    integer seed = 8;

    cpu #(.DataWidth(DataWidth), .PcWidth(26), .RegIdxWidth(6)) i_dut (
        .clock(clock), .rstN(rstN),
        .instr(instr), .instrLoaded(instrLoaded),
        .dataIn(dataIn), .dataLoaded(dataLoaded), .dataStored(dataStored),
        .instrAddr(instrAddr), .readInstr(readInstr),
        .dataAddr(dataAddr), .dataOut(dataOut),
        .readData(readData), .writeData(writeData)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        return (addr < MemWords) ? imem[addr[7:0]] : '0;
    endfunction

    function automatic logic [31:0] loadWord(input logic [31:0] addr);
        return (addr < MemWords) ? dmem[addr[7:0]] : ~addr;
    endfunction

    // True when the address shows up anywhere in the expected store list
    function automatic logic goldenHasAddr(input logic [31:0] addr);
        for (int k = 0; k < storeCount; k++) begin
            if (golden[storeBase + 2 * k] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Compare one store with the next golden address and data pair
    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] expAddr;
        logic [31:0] expData;
        assert (goldenHasAddr(addr)) else begin
            otherCount++;
            $display("unexpected store of %h to address %h", data, addr);
        end
        if (storeIdx < storeCount) begin
            expAddr = golden[storeBase + 2 * storeIdx];
            expData = golden[storeBase + 2 * storeIdx + 1];
            assert (addr == expAddr) else begin
                mismatchCount++;
                $display("mismatch dataAddr: store %0d got %h expected %h",
                         storeIdx, addr, expAddr);
            end
            assert (data == expData) else begin
                mismatchCount++;
                $display("mismatch dataOut: store %0d got %h expected %h",
                         storeIdx, data, expData);
            end
        end
        storeIdx++;
    endtask

    // Memory models, each request answered after 0 to 3 extra cycles
    always @(negedge clock) begin
        if (!rstN) begin
            instrLoaded  = 1'b0;
            dataLoaded   = 1'b0;
            dataStored   = 1'b0;
            instrWaiting = 1'b0;
            dataWaiting  = 1'b0;
        end else begin
            if (instrLoaded) begin
                instrLoaded = 1'b0;
            end else if (readInstr) begin
                if (!instrWaiting) begin
                    instrWaiting = 1'b1;
                    instrDelay   = $random(seed) & 3;
                end
                if (instrDelay == 0) begin
                    instr        = fetchWord(instrAddr);
                    instrLoaded  = 1'b1;
                    instrWaiting = 1'b0;
                end else begin
                    instrDelay--;
                end
            end
            if (dataLoaded || dataStored) begin
                dataLoaded = 1'b0;
                dataStored = 1'b0;
            end else if (readData || writeData) begin
                if (!dataWaiting) begin
                    dataWaiting = 1'b1;
                    dataDelay   = $random(seed) & 3;
                end
                if (dataDelay == 0) begin
                    if (readData) begin
                        dataIn     = loadWord(dataAddr);
                        dataLoaded = 1'b1;
                    end else begin
                        checkStore(dataAddr, dataOut);
                        if (dataAddr < MemWords) begin
                            dmem[dataAddr[7:0]] = dataOut;
                        end
                        dataStored = 1'b1;
                    end
                    dataWaiting = 1'b0;
                end else begin
                    dataDelay--;
                end
            end
        end
    end

    initial begin
        $readmemh("verif/cpuGolden.hex", golden);
        progLen    = golden[0];
        dataLen    = golden[1];
        storeCount = golden[2];
        loopFactor = golden[3];
        storeBase  = 4 + progLen + dataLen;
        for (int a = 0; a < MemWords; a++) begin
            imem[a] = '0;
            dmem[a] = 32'hD0000000 ^ (a << 12) ^ a;
        end
        for (int i = 0; i < progLen; i++) begin
            imem[i] = golden[4 + i];
            if (cpuPkg::opcodeT'(golden[4 + i][31:26]) == cpuPkg::OpStore) begin
                storesInProgram++;
            end
        end
        for (int i = 0; i < dataLen; i++) begin
            dmem[i] = golden[4 + progLen + i];
        end
        assert (storesInProgram > 0) else begin
            otherCount++;
            $display("golden program holds no store instruction");
        end
        cycleLimit = progLen * (32 + 2 * 4 + 4) * loopFactor;

        repeat (10) begin
            @(negedge clock);
            assert (!readData && !writeData) else begin
                otherCount++;
                $display("data request raised during reset");
            end
        end
        // Memory models still see reset in this falling edge
        rstN <= 1'b1;

        // First cycle with reset released
        @(negedge clock);
        assert (readInstr) else begin
            otherCount++;
            $display("no fetch request in the first cycle after reset");
        end
        assert (instrAddr == '0) else begin
            mismatchCount++;
            $display("mismatch instrAddr: got %h expected %h", instrAddr, 32'h0);
        end
        assert (!readData && !writeData) else begin
            otherCount++;
            $display("data request raised in the cycle reset was released");
        end

        while (storeIdx < storeCount && cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        if (storeIdx < storeCount) begin
            otherCount++;
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycleCount, storeIdx, storeCount);
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d of %0d stores checked",
                 mismatchCount, otherCount, storeIdx, storeCount);
        if (mismatchCount + otherCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/controlFsm.sv
`timescale 1ns/10ps

module controlFsm (
    input  logic clock,
    input  logic rstN,
    input  logic instrLoaded,
    input  logic dataLoaded,
    input  logic dataStored,
    input  logic aluDone,
    input  logic isLoad,
    input  logic isStore,
    output logic readInstr,
    output logic readData,
    output logic writeData,
    output logic decodeEn,
    output logic aluStart,
    output logic regWrite,
    output logic pcUpdate
);

    cpuPkg::ctrlStateT state;
    cpuPkg::ctrlStateT nextState;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::StFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::StFetch: begin
                if (instrLoaded) begin
                    nextState = cpuPkg::StDecode;
                end
            end
            cpuPkg::StDecode: nextState = cpuPkg::StExecute;
            cpuPkg::StExecute: begin
                if (aluDone) begin
                    if (isLoad) begin
                        nextState = cpuPkg::StMemRead;
                    end else if (isStore) begin
                        nextState = cpuPkg::StMemWrite;
                    end else begin
                        nextState = cpuPkg::StWriteback;
                    end
                end
            end
            cpuPkg::StMemRead: begin
                if (dataLoaded) begin
                    nextState = cpuPkg::StWriteback;
                end
            end
            cpuPkg::StMemWrite: begin
                if (dataStored) begin
                    nextState = cpuPkg::StWriteback;
                end
            end
            cpuPkg::StWriteback: nextState = cpuPkg::StFetch;
            default: nextState = cpuPkg::StFetch;
        endcase
    end

    // Start pulse lands in the first execute cycle, once decoded fields are valid
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            aluStart <= 1'b0;
        end else begin
            aluStart <= (state == cpuPkg::StDecode);
        end
    end

    // Request levels drop the cycle after their pulse
    assign readInstr = (state == cpuPkg::StFetch);
    assign decodeEn  = (state == cpuPkg::StDecode);
    assign readData  = (state == cpuPkg::StMemRead);
    assign writeData = (state == cpuPkg::StMemWrite);
    assign regWrite  = (state == cpuPkg::StWriteback);
    assign pcUpdate  = (state == cpuPkg::StWriteback);

    dataReqExclusive: assert property (@(posedge clock) disable iff (!rstN)
        !(readData && writeData));

    fetchNotWithData: assert property (@(posedge clock) disable iff (!rstN)
        readInstr |-> !(readData || writeData));

endmodule

//--- verilog/cpu.sv
`timescale 1ns/10ps

module cpu #(
    parameter int DataWidth   = 32,
    parameter int PcWidth     = 26,
    parameter int RegIdxWidth = 6
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] instr,
    input  logic                 instrLoaded,
    input  logic [DataWidth-1:0] dataIn,
    input  logic                 dataLoaded,
    input  logic                 dataStored,
    output logic [DataWidth-1:0] instrAddr,
    output logic                 readInstr,
    output logic [DataWidth-1:0] dataAddr,
    output logic [DataWidth-1:0] dataOut,
    output logic                 readData,
    output logic                 writeData
);

    logic [RegIdxWidth-1:0] rs1Idx;
    logic [RegIdxWidth-1:0] rs2Idx;
    logic [RegIdxWidth-1:0] rdIdx;
    logic [DataWidth-1:0]   imm;
    logic [DataWidth-1:0]   rs1Data;
    logic [DataWidth-1:0]   rs2Data;
    logic [DataWidth-1:0]   aluResult;
    logic [PcWidth-1:0]     pc;
    cpuPkg::aluOpT          aluOp;
    logic useImm, usePc, isLoad, isStore, isJal, isJumpReg;
    logic isBranch, branchOnZero, writesReg;
    logic decodeEn, aluStart, aluDone, regWrite, pcUpdate;

    assign instrAddr = {{(DataWidth-PcWidth){1'b0}}, pc};
    assign dataAddr  = aluResult;
    assign dataOut   = rs2Data;

    instrDecoder #(.DataWidth(DataWidth), .RegIdxWidth(RegIdxWidth)) i_decoder (
        .clock(clock), .rstN(rstN),
        .decodeEn(decodeEn),
        .instr(instr),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
        .imm(imm),
        .useImm(useImm), .usePc(usePc),
        .isLoad(isLoad), .isStore(isStore),
        .isJal(isJal), .isJumpReg(isJumpReg),
        .isBranch(isBranch), .branchOnZero(branchOnZero),
        .writesReg(writesReg),
        .aluOp(aluOp)
    );

    executeUnit #(.DataWidth(DataWidth), .PcWidth(PcWidth)) i_execute (
        .clock(clock), .rstN(rstN),
        .aluStart(aluStart),
        .aluOp(aluOp),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(imm),
        .pc(pc),
        .useImm(useImm), .usePc(usePc),
        .aluDone(aluDone),
        .aluResult(aluResult)
    );

    writeBack #(
        .DataWidth(DataWidth), .PcWidth(PcWidth), .RegIdxWidth(RegIdxWidth)
    ) i_writeBack (
        .clock(clock), .rstN(rstN),
        .regWrite(regWrite),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
        .aluResult(aluResult),
        .dataIn(dataIn),
        .pc(pc),
        .isLoad(isLoad), .isJal(isJal), .writesReg(writesReg),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    pcUnit #(.DataWidth(DataWidth), .PcWidth(PcWidth)) i_pc (
        .clock(clock), .rstN(rstN),
        .pcUpdate(pcUpdate),
        .rs1Data(rs1Data),
        .aluResult(aluResult),
        .isJal(isJal), .isJumpReg(isJumpReg),
        .isBranch(isBranch), .branchOnZero(branchOnZero),
        .pc(pc)
    );

    controlFsm i_control (
        .clock(clock), .rstN(rstN),
        .instrLoaded(instrLoaded),
        .dataLoaded(dataLoaded), .dataStored(dataStored),
        .aluDone(aluDone),
        .isLoad(isLoad), .isStore(isStore),
        .readInstr(readInstr), .readData(readData), .writeData(writeData),
        .decodeEn(decodeEn), .aluStart(aluStart),
        .regWrite(regWrite), .pcUpdate(pcUpdate)
    );

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

    // Opcode sits in the top six bits of every instruction word
    typedef enum logic [5:0] {
        OpAdd   = 6'h00,
        OpSub   = 6'h01,
        OpAnd   = 6'h02,
        OpOr    = 6'h03,
        OpXor   = 6'h04,
        OpSll   = 6'h05,
        OpSrl   = 6'h06,
        OpMul   = 6'h07,
        OpAddi  = 6'h08,
        OpLoad  = 6'h10,
        OpStore = 6'h11,
        OpJal   = 6'h20,
        OpJr    = 6'h21,
        OpBeqz  = 6'h22,
        OpBnez  = 6'h23
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSll,
        AluSrl,
        AluMul
    } aluOpT;

    typedef enum logic [2:0] {
        StFetch,
        StDecode,
        StExecute,
        StMemRead,
        StMemWrite,
        StWriteback
    } ctrlStateT;

    // Field layout: opcode | rd | rs1 | rs2, immediate in the low bits
    // The immediate overlaps rs2, so a store takes its data register from rd
    localparam int OpcodeLsb = 26;
    localparam int RdLsb     = 20;
    localparam int Rs1Lsb    = 14;
    localparam int Rs2Lsb    = 8;
    localparam int ImmWidth  = 14;

endpackage

//--- verilog/executeUnit.sv
`timescale 1ns/10ps

module executeUnit #(
    parameter int DataWidth = 32,
    parameter int PcWidth   = 26
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 aluStart,
    input  cpuPkg::aluOpT        aluOp,
    input  logic [DataWidth-1:0] rs1Data,
    input  logic [DataWidth-1:0] rs2Data,
    input  logic [DataWidth-1:0] imm,
    input  logic [PcWidth-1:0]   pc,
    input  logic                 useImm,
    input  logic                 usePc,
    output logic                 aluDone,
    output logic [DataWidth-1:0] aluResult
);

    localparam int CntWidth = $clog2(DataWidth);
    localparam logic [CntWidth-1:0] LastStep = CntWidth'(DataWidth - 1);

    logic [DataWidth-1:0] op1;
    logic [DataWidth-1:0] op2;
    logic [DataWidth-1:0] quickResult;
    logic [DataWidth-1:0] mcand;
    logic [DataWidth-1:0] mplier;
    logic [CntWidth-1:0]  stepCnt;
    logic                 busy;

    assign op1 = usePc ? {{(DataWidth-PcWidth){1'b0}}, pc} : rs1Data;
    assign op2 = useImm ? imm : rs2Data;

    always_comb begin
        case (aluOp)
            cpuPkg::AluAdd: quickResult = op1 + op2;
            cpuPkg::AluSub: quickResult = op1 - op2;
            cpuPkg::AluAnd: quickResult = op1 & op2;
            cpuPkg::AluOr:  quickResult = op1 | op2;
            cpuPkg::AluXor: quickResult = op1 ^ op2;
            cpuPkg::AluSll: quickResult = op1 << op2[CntWidth-1:0];
            cpuPkg::AluSrl: quickResult = op1 >> op2[CntWidth-1:0];
            default:        quickResult = '0;
        endcase
    end

    // Step counter and done pulse
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            busy    <= 1'b0;
            aluDone <= 1'b0;
            stepCnt <= '0;
        end else begin
            aluDone <= 1'b0;
            if (aluStart) begin
                if (aluOp == cpuPkg::AluMul) begin
                    busy    <= 1'b1;
                    stepCnt <= CntWidth'(1);
                end else begin
                    aluDone <= 1'b1;
                end
            end else if (busy) begin
                stepCnt <= stepCnt + 1'b1;
                if (stepCnt == LastStep) begin
                    busy    <= 1'b0;
                    aluDone <= 1'b1;
                end
            end
        end
    end

    // Shift-and-add, first partial product taken on the start edge
    always_ff @(posedge clock) begin
        if (aluStart) begin
            if (aluOp == cpuPkg::AluMul) begin
                aluResult <= op2[0] ? op1 : '0;
                mcand     <= op1 << 1;
                mplier    <= op2 >> 1;
            end else begin
                aluResult <= quickResult;
            end
        end else if (busy) begin
            if (mplier[0]) begin
                aluResult <= aluResult + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Done follows a quick start by one cycle, a multiply start by DataWidth cycles
    aluDoneHasCause: assert property (@(posedge clock) disable iff (!rstN)
        aluDone |-> $past(aluStart && aluOp != cpuPkg::AluMul)
                    || $past(aluStart && aluOp == cpuPkg::AluMul, DataWidth));

    noStartWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
        aluStart |-> !busy);

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder #(
    parameter int DataWidth   = 32,
    parameter int RegIdxWidth = 6
) (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   decodeEn,
    input  logic [DataWidth-1:0]   instr,
    output logic [RegIdxWidth-1:0] rs1Idx,
    output logic [RegIdxWidth-1:0] rs2Idx,
    output logic [RegIdxWidth-1:0] rdIdx,
    output logic [DataWidth-1:0]   imm,
    output logic                   useImm,
    output logic                   usePc,
    output logic                   isLoad,
    output logic                   isStore,
    output logic                   isJal,
    output logic                   isJumpReg,
    output logic                   isBranch,
    output logic                   branchOnZero,
    output logic                   writesReg,
    output cpuPkg::aluOpT          aluOp
);

    logic [DataWidth-1:0] instrReg;
    cpuPkg::opcodeT       opcode;

    // Instruction held for the rest of the instruction's life
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            instrReg <= '0;
        end else if (decodeEn) begin
            instrReg <= instr;
        end
    end

    assign opcode = cpuPkg::opcodeT'(instrReg[cpuPkg::OpcodeLsb +: $bits(cpuPkg::opcodeT)]);
    assign rdIdx  = instrReg[cpuPkg::RdLsb +: RegIdxWidth];
    assign rs1Idx = instrReg[cpuPkg::Rs1Lsb +: RegIdxWidth];
    // Store data register lives in the rd slot
    assign rs2Idx = isStore ? instrReg[cpuPkg::RdLsb +: RegIdxWidth]
                            : instrReg[cpuPkg::Rs2Lsb +: RegIdxWidth];
    assign imm    = {{(DataWidth-cpuPkg::ImmWidth){instrReg[cpuPkg::ImmWidth-1]}},
                     instrReg[cpuPkg::ImmWidth-1:0]};

    always_comb begin
        aluOp        = cpuPkg::AluAdd;
        useImm       = 1'b0;
        usePc        = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        isJal        = 1'b0;
        isJumpReg    = 1'b0;
        isBranch     = 1'b0;
        branchOnZero = 1'b0;
        writesReg    = 1'b0;
        case (opcode)
            cpuPkg::OpAdd: begin aluOp = cpuPkg::AluAdd; writesReg = 1'b1; end
            cpuPkg::OpSub: begin aluOp = cpuPkg::AluSub; writesReg = 1'b1; end
            cpuPkg::OpAnd: begin aluOp = cpuPkg::AluAnd; writesReg = 1'b1; end
            cpuPkg::OpOr:  begin aluOp = cpuPkg::AluOr;  writesReg = 1'b1; end
            cpuPkg::OpXor: begin aluOp = cpuPkg::AluXor; writesReg = 1'b1; end
            cpuPkg::OpSll: begin aluOp = cpuPkg::AluSll; writesReg = 1'b1; end
            cpuPkg::OpSrl: begin aluOp = cpuPkg::AluSrl; writesReg = 1'b1; end
            cpuPkg::OpMul: begin aluOp = cpuPkg::AluMul; writesReg = 1'b1; end
            cpuPkg::OpAddi: begin
                useImm    = 1'b1;
                writesReg = 1'b1;
            end
            cpuPkg::OpLoad: begin
                useImm    = 1'b1;
                isLoad    = 1'b1;
                writesReg = 1'b1;
            end
            cpuPkg::OpStore: begin
                useImm  = 1'b1;
                isStore = 1'b1;
            end
            // Relative targets come out of the ALU as pc + imm
            cpuPkg::OpJal: begin
                useImm    = 1'b1;
                usePc     = 1'b1;
                isJal     = 1'b1;
                writesReg = 1'b1;
            end
            cpuPkg::OpJr: isJumpReg = 1'b1;
            cpuPkg::OpBeqz, cpuPkg::OpBnez: begin
                useImm       = 1'b1;
                usePc        = 1'b1;
                isBranch     = 1'b1;
                branchOnZero = (opcode == cpuPkg::OpBeqz);
            end
            default: ;  // unknown opcode behaves as a no-op
        endcase
    end

endmodule

//--- verilog/pcUnit.sv
`timescale 1ns/10ps

module pcUnit #(
    parameter int DataWidth = 32,
    parameter int PcWidth   = 26
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 pcUpdate,
    input  logic [DataWidth-1:0] rs1Data,
    input  logic [DataWidth-1:0] aluResult,
    input  logic                 isJal,
    input  logic                 isJumpReg,
    input  logic                 isBranch,
    input  logic                 branchOnZero,
    output logic [PcWidth-1:0]   pc
);

    logic               condTrue;
    logic               takeRelative;
    logic [PcWidth-1:0] nextPc;

    // Branch condition on rs1
    assign condTrue     = branchOnZero ? (rs1Data == '0) : (rs1Data != '0);
    assign takeRelative = isJal || (isBranch && condTrue);

    always_comb begin
        if (isJumpReg) begin
            nextPc = rs1Data[PcWidth-1:0];
        end else if (takeRelative) begin
            nextPc = aluResult[PcWidth-1:0];
        end else begin
            nextPc = pc + PcWidth'(1);
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcUpdate) begin
            pc <= nextPc;
        end
    end

endmodule

//--- verilog/writeBack.sv
`timescale 1ns/10ps

module writeBack #(
    parameter int DataWidth   = 32,
    parameter int PcWidth     = 26,
    parameter int RegIdxWidth = 6
) (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   regWrite,
    input  logic [RegIdxWidth-1:0] rs1Idx,
    input  logic [RegIdxWidth-1:0] rs2Idx,
    input  logic [RegIdxWidth-1:0] rdIdx,
    input  logic [DataWidth-1:0]   aluResult,
    input  logic [DataWidth-1:0]   dataIn,
    input  logic [PcWidth-1:0]     pc,
    input  logic                   isLoad,
    input  logic                   isJal,
    input  logic                   writesReg,
    output logic [DataWidth-1:0]   rs1Data,
    output logic [DataWidth-1:0]   rs2Data
);

    localparam int NumRegs = 2 ** RegIdxWidth;

    logic [DataWidth-1:0] regs [NumRegs];
    logic [DataWidth-1:0] wrData;
    logic                 wrEn;

    // Link value is the return address pc + 1
    assign wrData = isLoad ? dataIn :
                    isJal  ? {{(DataWidth-PcWidth){1'b0}}, pc + PcWidth'(1)} :
                             aluResult;
    assign wrEn   = regWrite && writesReg && (rdIdx != '0);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[rdIdx] <= wrData;
        end
    end

    assign rs1Data = regs[rs1Idx];
    assign rs2Data = regs[rs2Idx];

    // r0 stays zero for the whole run
    zeroRegStaysZero: assert property (@(posedge clock) disable iff (!rstN)
        regs[0] == '0);

endmodule
